// File: flist.f
+incdir+.
sample_link_pkg.sv
link_settings_regs.sv
sample_fifo_32to16.sv
serdes_tx_framer.sv
sample_link_core.sv
tb_sample_link.sv

// File: run_sim.sh
#!/bin/sh
# Build the sample link testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_sample_link \
   -f flist.f > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/Vtb_sample_link > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0

// File: tb_sample_link.sv
////////////////////
// Sample link testbench
// Register access, alignment, sample order and overrun counting
////////////////////
`include "sample_link_macros.svh"

module tb_sample_link;

   logic                       dsp_clk;
   logic                       rst_n;
   sample_link_pkg::wb_req_t   wb_req;
   sample_link_pkg::wb_rsp_t   wb_rsp;
   logic [`SL_SAMPLE_W-1:0]    sample;
   logic                       sample_stb;
   sample_link_pkg::ser_word_t ser;
   logic [`SL_LED_W-1:0]       leds;

   int errors = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   int seen_halves = 0;
   bit check_order = 1'b0;
   // Halves still owed on the serial side, upper first
   logic [`SL_SER_W-1:0] exp_q[$];

   sample_link_core i_sample_link_core (
      .dsp_clk      (dsp_clk),
      .rst_n_i      (rst_n),
      .wb_req_i     (wb_req),
      .wb_rsp_o     (wb_rsp),
      .sample_i     (sample),
      .sample_stb_i (sample_stb),
      .ser_o        (ser),
      .leds_o       (leds)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #4 dsp_clk = ~dsp_clk;
   end

   ////////////////////
   // Checks
   ////////////////////

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
         errors++;
      end
   endtask

   // Reference LED mix, hardware bits 1 run, 2 not empty, 3 full
   function automatic logic [7:0] led_mix(input logic [7:0] src, input logic [7:0] sw,
                                          input logic run, input logic empty,
                                          input logic full);
      logic [7:0] hw;
      logic [7:0] mix;
      hw    = '0;
      hw[1] = run;
      hw[2] = !empty;
      hw[3] = full;
      // Each bit picks hardware where its source bit is set
      for (int i = 0; i < 8; i++) begin
         mix[i] = src[i] ? hw[i] : sw[i];
      end
      return mix;
   endfunction

   kmsb_never_set: assert property (@(posedge dsp_clk) disable iff (!rst_n) !ser.kmsb)
      else begin
         $display("ERR %0t ser_o.kmsb expected 0 actual 1", $time);
         errors++;
      end

   // K words carry only the idle comma
   comma_word_value: assert property (
      @(posedge dsp_clk) disable iff (!rst_n) ser.klsb |-> ser.data == `SL_COMMA)
      else begin
         $display("ERR %0t ser_o.data expected %h actual %h", $time, `SL_COMMA,
                  $sampled(ser.data));
         errors++;
      end

   ack_single_cycle: assert property (
      @(posedge dsp_clk) disable iff (!rst_n) wb_rsp.ack |=> !wb_rsp.ack)
      else begin
         $display("Wishbone ack stayed high for more than one cycle at %0t", $time);
         errors++;
      end

   ack_inside_cycle: assert property (
      @(posedge dsp_clk) disable iff (!rst_n) wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
      else begin
         $display("Wishbone ack came outside a bus cycle at %0t", $time);
         errors++;
      end

   // Serial monitor, data words against the expected halves
   always @(negedge dsp_clk) begin
      if (rst_n && !ser.klsb) begin
         seen_halves++;
         if (check_order) begin
            if (exp_q.size() == 0) begin
               $display("Data word %h on ser_o was never sent at %0t", ser.data, $time);
               errors++;
            end else begin
               check_val("ser_o.data", exp_q.pop_front(), ser.data);
            end
         end
      end
   end

   ////////////////////
   // Bus and stimulus tasks
   ////////////////////

   task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
      int waited;
      waited = 0;
      @(posedge dsp_clk);
      wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
      // Ack looked at on the falling edge
      do begin
         @(negedge dsp_clk);
         waited++;
      end while (!wb_rsp.ack && waited < 10);
      if (!wb_rsp.ack) begin
         $display("No Wishbone ack for word %0d at %0t", adr, $time);
         errors++;
      end
      rdat = wb_rsp.dat;
      @(posedge dsp_clk);
      wb_req <= '0;
   endtask

   task automatic wb_write(input logic [2:0] adr, input logic [31:0] wdat);
      logic [31:0] unused;
      wb_access(1'b1, adr, wdat, unused);
   endtask

   task automatic wb_read(input logic [2:0] adr, output logic [31:0] rdat);
      wb_access(1'b0, adr, '0, rdat);
   endtask

   task automatic send_sample(input logic [31:0] s);
      @(posedge dsp_clk);
      sample     <= s;
      sample_stb <= 1'b1;
      @(posedge dsp_clk);
      sample_stb <= 1'b0;
   endtask

   // Returns once the link sends only commas for a while
   task automatic wait_idle(input int quiet);
      int run_len;
      int waited;
      run_len = 0;
      waited  = 0;
      while (run_len < quiet && waited < 400) begin
         @(negedge dsp_clk);
         waited++;
         run_len = ser.klsb ? run_len + 1 : 0;
      end
      if (run_len < quiet) begin
         $display("Serial output never went idle at %0t", $time);
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int err_before);
      if (errors == err_before) begin
         tests_passed++;
         $display("Test %s: ok", name);
      end else begin
         tests_failed++;
         $display("Test %s: FAILED with %0d errors", name, errors - err_before);
      end
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin
      logic [31:0] rd;
      logic [31:0] s;
      int          err0;
      int          base;
      int          ov0;
      int          seen;
      int          waited;
      void'($urandom(7207));
      wb_req     = '0;
      sample     = '0;
      sample_stb = 1'b0;
      rst_n      = 1'b0;
      repeat (2) @(posedge dsp_clk);
      rst_n <= 1'b1;

      // Alignment commas and reset values
      err0 = errors;
      repeat (`SL_ALIGN_WORDS) begin
         @(negedge dsp_clk);
         check_val("ser_o.klsb", 1, ser.klsb);
      end
      wb_read(sample_link_pkg::REG_LED_SRC, rd);
      check_val("REG_LED_SRC", `SL_LED_SRC_RST, rd);
      wb_read(sample_link_pkg::REG_COMPAT, rd);
      check_val("REG_COMPAT", `SL_COMPAT_NUM, rd);
      wb_read(sample_link_pkg::REG_OVERRUN, rd);
      check_val("REG_OVERRUN", 0, rd);
      // Empty flag alone in bit 0
      wb_read(sample_link_pkg::REG_STATUS, rd);
      check_val("REG_STATUS", 32'h1, rd);
      finish_test("reset", err0);

      // Register write and readback
      err0 = errors;
      wb_write(sample_link_pkg::REG_LED_SW, 32'h5A);
      wb_read(sample_link_pkg::REG_LED_SW, rd);
      check_val("REG_LED_SW", 32'h5A, rd);
      wb_write(sample_link_pkg::REG_CTRL, 32'h1);
      wb_read(sample_link_pkg::REG_CTRL, rd);
      check_val("REG_CTRL", 32'h1, rd);
      wb_write(sample_link_pkg::REG_CTRL, 32'h0);
      wb_read(sample_link_pkg::REG_CTRL, rd);
      check_val("REG_CTRL", 32'h0, rd);
      wb_write(sample_link_pkg::REG_COMPAT, 32'hFF);
      wb_read(sample_link_pkg::REG_COMPAT, rd);
      check_val("REG_COMPAT", `SL_COMPAT_NUM, rd);
      wb_read(3'd7, rd);
      check_val("unmapped word 7", 0, rd);
      finish_test("registers", err0);

      // LED mix, FIFO known empty
      err0 = errors;
      @(negedge dsp_clk);
      check_val("leds_o", led_mix(`SL_LED_SRC_RST, 8'h5A, 1'b0, 1'b1, 1'b0), leds);
      wb_write(sample_link_pkg::REG_LED_SRC, 32'h0F);
      wb_write(sample_link_pkg::REG_LED_SW, 32'hA5);
      wb_write(sample_link_pkg::REG_CTRL, 32'h1);
      @(negedge dsp_clk);
      check_val("leds_o", led_mix(8'h0F, 8'hA5, 1'b1, 1'b1, 1'b0), leds);
      wb_write(sample_link_pkg::REG_LED_SRC, 32'hF0);
      wb_write(sample_link_pkg::REG_CTRL, 32'h0);
      @(negedge dsp_clk);
      check_val("leds_o", led_mix(8'hF0, 8'hA5, 1'b0, 1'b1, 1'b0), leds);
      finish_test("led mix", err0);

      // Sample order, stopped then running
      err0 = errors;
      check_order = 1'b1;
      base = seen_halves;
      repeat (4) send_sample($urandom());
      repeat (10) @(negedge dsp_clk);
      check_val("data halves while stopped", base, seen_halves);
      wb_write(sample_link_pkg::REG_CTRL, 32'h1);
      repeat (12) begin
         s = $urandom();
         exp_q.push_back(s[31:16]);
         exp_q.push_back(s[15:0]);
         send_sample(s);
         @(posedge dsp_clk);
      end
      waited = 0;
      while (exp_q.size() != 0 && waited < 100) begin
         @(negedge dsp_clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         $display("%0d sample halves never reached ser_o", exp_q.size());
         errors++;
      end
      wb_read(sample_link_pkg::REG_STATUS, rd);
      check_val("REG_STATUS", 32'h1, rd);
      check_order = 1'b0;
      finish_test("sample order", err0);

      // Back-to-back strobes overflow the FIFO
      err0 = errors;
      wb_read(sample_link_pkg::REG_OVERRUN, rd);
      ov0  = rd;
      base = seen_halves;
      repeat (40) begin
         @(posedge dsp_clk);
         sample     <= $urandom();
         sample_stb <= 1'b1;
      end
      @(posedge dsp_clk);
      sample_stb <= 1'b0;
      wait_idle(8);
      seen = (seen_halves - base) / 2;
      check_val("data halves parity", 0, (seen_halves - base) % 2);
      wb_read(sample_link_pkg::REG_OVERRUN, rd);
      check_val("REG_OVERRUN", ov0 + 40 - seen, rd);
      wb_read(sample_link_pkg::REG_STATUS, rd);
      check_val("REG_STATUS", 32'h1, rd);
      finish_test("overrun", err0);

      $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: sample_link_core.sv
////////////////////
// Sample link top
// Register block, sample FIFO and SERDES framer on dsp_clk
////////////////////
`include "sample_link_macros.svh"

module sample_link_core (
   input  logic                       dsp_clk,
   input  logic                       rst_n_i,
   // Wishbone settings bus
   input  sample_link_pkg::wb_req_t   wb_req_i,
   output sample_link_pkg::wb_rsp_t   wb_rsp_o,
   // Receive samples
   input  logic [`SL_SAMPLE_W-1:0]    sample_i,
   input  logic                       sample_stb_i,
   // SERDES transmit and LEDs
   output sample_link_pkg::ser_word_t ser_o,
   output logic [`SL_LED_W-1:0]       leds_o
);

   // Control and status between blocks
   logic                          run_rx;
   logic                          drop;
   sample_link_pkg::fifo_status_t fifo_status;

   // FIFO to framer
   logic                          deq_rdy;
   logic                          deq_en;
   logic [`SL_SER_W-1:0]          fifo_dat;

   ////////////////////
   // Settings
   ////////////////////
   link_settings_regs i_link_settings_regs (
      .dsp_clk       (dsp_clk),
      .rst_n_i       (rst_n_i),
      .wb_req_i      (wb_req_i),
      .wb_rsp_o      (wb_rsp_o),
      .fifo_status_i (fifo_status),
      .drop_i        (drop),
      .run_rx_o      (run_rx),
      .leds_o        (leds_o)
   );

   // Sample queue, width change 32 to 16
   sample_fifo_32to16 i_sample_fifo_32to16 (
      .dsp_clk   (dsp_clk),
      .rst_n_i   (rst_n_i),
      .dat_i     (sample_i),
      .stb_i     (sample_stb_i),
      .run_i     (run_rx),
      .deq_en_i  (deq_en),
      .dat_o     (fifo_dat),
      .deq_rdy_o (deq_rdy),
      .status_o  (fifo_status),
      .drop_o    (drop)
   );

   // Serial side drains one half per cycle
   serdes_tx_framer i_serdes_tx_framer (
      .dsp_clk   (dsp_clk),
      .rst_n_i   (rst_n_i),
      .deq_rdy_i (deq_rdy),
      .dat_i     (fifo_dat),
      .deq_en_o  (deq_en),
      .ser_o     (ser_o)
   );

endmodule

// File: serdes_tx_framer.sv
////////////////////
// SERDES transmit framer
// Alignment commas, then data halves or idle commas
////////////////////
`include "sample_link_macros.svh"

module serdes_tx_framer (
   input  logic                       dsp_clk,
   input  logic                       rst_n_i,
   // FIFO side
   input  logic                       deq_rdy_i,
   input  logic [`SL_SER_W-1:0]       dat_i,
   output logic                       deq_en_o,
   // SERDES transmit pins
   output sample_link_pkg::ser_word_t ser_o
);

   localparam int unsigned ALN_W = $clog2(`SL_ALIGN_WORDS);

   sample_link_pkg::framer_state_e state_q;
   sample_link_pkg::framer_state_e state_d;
   logic [ALN_W-1:0]               align_cnt;
   logic                           align_done;

   assign align_done = (align_cnt == ALN_W'(`SL_ALIGN_WORDS - 1));

   // No pull while link is aligning
   assign deq_en_o = deq_rdy_i && (state_q != sample_link_pkg::FR_ALIGN);

   ////////////////////
   // State machine
   ////////////////////

   always_comb begin
      state_d = state_q;
      case (state_q)
         sample_link_pkg::FR_ALIGN: begin
            if (align_done) begin
               state_d = sample_link_pkg::FR_IDLE;
            end
         end
         // State follows what goes out next cycle
         sample_link_pkg::FR_IDLE,
         sample_link_pkg::FR_DATA: begin
            state_d = deq_en_o ? sample_link_pkg::FR_DATA : sample_link_pkg::FR_IDLE;
         end
         default: begin
            state_d = sample_link_pkg::FR_ALIGN;
         end
      endcase
   end

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= sample_link_pkg::FR_ALIGN;
         align_cnt <= '0;
      end else begin
         state_q <= state_d;
         // Counts commas only during alignment
         if (state_q == sample_link_pkg::FR_ALIGN) begin
            align_cnt <= align_cnt + 1'b1;
         end
      end
   end

   ////////////////////
   // Output word
   ////////////////////

   // Registered, taken half shows one cycle later
   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ser_o <= '{data: `SL_COMMA, klsb: 1'b1, kmsb: 1'b0};
      end else if (deq_en_o) begin
         ser_o <= '{data: dat_i, klsb: 1'b0, kmsb: 1'b0};
      end else begin
         ser_o <= '{data: `SL_COMMA, klsb: 1'b1, kmsb: 1'b0};
      end
   end

   // Upper K flag unused on this link
   kmsb_low: assert property (
      @(posedge dsp_clk) disable iff (!rst_n_i)
      !ser_o.kmsb
   );

endmodule

// File: sample_fifo_32to16.sv
////////////////////
// Sample FIFO, 32 bits in, 16 bits out
// Upper half leaves first, drops are flagged when full
////////////////////
`include "sample_link_macros.svh"

module sample_fifo_32to16 (
   input  logic                          dsp_clk,
   input  logic                          rst_n_i,
   // Enqueue side
   input  logic [`SL_SAMPLE_W-1:0]       dat_i,
   input  logic                          stb_i,
   input  logic                          run_i,
   // Dequeue side
   input  logic                          deq_en_i,
   output logic [`SL_SER_W-1:0]          dat_o,
   output logic                          deq_rdy_o,
   // Status
   output sample_link_pkg::fifo_status_t status_o,
   output logic                          drop_o
);

   // Pointers carry one wrap bit
   localparam int unsigned CNT_W = `SL_FIFO_AW + 1;
   localparam logic [CNT_W-1:0] DEPTH = CNT_W'(`SL_FIFO_DEPTH);

   logic [`SL_SAMPLE_W-1:0] mem [`SL_FIFO_DEPTH];
   logic [CNT_W-1:0]        wr_ptr;
   logic [CNT_W-1:0]        rd_ptr;
   logic                    rd_half;
   logic [CNT_W-1:0]        count;
   logic [CNT_W:0]          occ_halves;
   logic                    full;
   logic                    empty;
   logic                    wr_en;

   assign count = wr_ptr - rd_ptr;
   assign full  = (count == DEPTH);
   assign empty = (count == '0);

   // Samples only enter while running
   assign wr_en  = stb_i && run_i && !full;
   assign drop_o = stb_i && run_i && full;

   ////////////////////
   // Write side
   ////////////////////

   always_ff @(posedge dsp_clk) begin
      if (wr_en) begin
         mem[wr_ptr[`SL_FIFO_AW-1:0]] <= dat_i;
      end
   end

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
      end else if (wr_en) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   ////////////////////
   // Read side
   ////////////////////

   // Half select, 0 upper, 1 lower
   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_ptr  <= '0;
         rd_half <= 1'b0;
      end else if (deq_en_i) begin
         rd_half <= !rd_half;
         // Entry freed after its lower half
         if (rd_half) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   assign dat_o = rd_half ? mem[rd_ptr[`SL_FIFO_AW-1:0]][`SL_SER_W-1:0]
                          : mem[rd_ptr[`SL_FIFO_AW-1:0]][`SL_SAMPLE_W-1:`SL_SER_W];

   assign deq_rdy_o = !empty;

   // Halves held, less the upper half already sent
   assign occ_halves = {count, 1'b0} - {{CNT_W{1'b0}}, rd_half};

   // Top count clips at 31, full marks the last half
   assign status_o.occupancy = occ_halves[CNT_W] ? '1 : occ_halves[CNT_W-1:0];
   assign status_o.full      = full;
   assign status_o.empty     = empty;

   // Buffer never overwritten, pointers never further apart than the depth
   no_write_when_full: assert property (
      @(posedge dsp_clk) disable iff (!rst_n_i)
      count <= DEPTH
   );

   // Framer only pulls halves that exist
   deq_only_when_ready: assert property (
      @(posedge dsp_clk) disable iff (!rst_n_i)
      deq_en_i |-> deq_rdy_o
   );

endmodule

// File: link_settings_regs.sv
////////////////////
// Link settings registers
// Wishbone classic slave with run enable, LED mix and overrun count
////////////////////
`include "sample_link_macros.svh"

module link_settings_regs (
   input  logic                          dsp_clk,
   input  logic                          rst_n_i,
   // Wishbone slave
   input  sample_link_pkg::wb_req_t      wb_req_i,
   output sample_link_pkg::wb_rsp_t      wb_rsp_o,
   // FIFO side
   input  sample_link_pkg::fifo_status_t fifo_status_i,
   input  logic                          drop_i,
   output logic                          run_rx_o,
   // Front panel
   output logic [`SL_LED_W-1:0]          leds_o
);

   ////////////////////
   // Bus handshake
   ////////////////////

   logic                  ack_q;
   logic [`SL_WB_DW-1:0]  rd_dat_q;
   logic [`SL_WB_DW-1:0]  rd_mux;
   logic                  access;
   logic                  wr_stb;

   // New access only while ack is low, so one ack per strobe
   assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;
   assign wr_stb = access && wb_req_i.we;

   // Settings and counter
   logic                  run_rx_q;
   logic [`SL_LED_W-1:0]  led_sw_q;
   logic [`SL_LED_W-1:0]  led_src_q;
   logic [`SL_WB_DW-1:0]  overrun_q;

   // Ack one cycle after the request
   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   // Read data captured with the ack
   always_ff @(posedge dsp_clk) begin
      if (access) begin
         rd_dat_q <= rd_mux;
      end
   end

   assign wb_rsp_o.ack = ack_q;
   assign wb_rsp_o.dat = rd_dat_q;

   ////////////////////
   // Register writes
   ////////////////////

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         run_rx_q  <= 1'b0;
         led_sw_q  <= '0;
         led_src_q <= `SL_LED_SRC_RST;
      end else if (wr_stb) begin
         case (wb_req_i.adr)
            sample_link_pkg::REG_CTRL: begin
               run_rx_q <= wb_req_i.dat[0];
            end
            sample_link_pkg::REG_LED_SW: begin
               led_sw_q <= wb_req_i.dat[`SL_LED_W-1:0];
            end
            sample_link_pkg::REG_LED_SRC: begin
               led_src_q <= wb_req_i.dat[`SL_LED_W-1:0];
            end
            // Read-only and unmapped words ignore writes
            default: begin
            end
         endcase
      end
   end

   // Dropped samples, one per pulse
   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         overrun_q <= '0;
      end else if (drop_i) begin
         overrun_q <= overrun_q + 1'b1;
      end
   end

   ////////////////////
   // Readback
   ////////////////////

   always_comb begin
      rd_mux = '0;
      case (wb_req_i.adr)
         sample_link_pkg::REG_CTRL:    rd_mux[0] = run_rx_q;
         sample_link_pkg::REG_LED_SW:  rd_mux[`SL_LED_W-1:0] = led_sw_q;
         sample_link_pkg::REG_LED_SRC: rd_mux[`SL_LED_W-1:0] = led_src_q;
         sample_link_pkg::REG_STATUS:  rd_mux[$bits(fifo_status_i)-1:0] = fifo_status_i;
         sample_link_pkg::REG_OVERRUN: rd_mux = overrun_q;
         sample_link_pkg::REG_COMPAT:  rd_mux = `SL_WB_DW'(`SL_COMPAT_NUM);
         // Unmapped words read as zero
         default:                      rd_mux = '0;
      endcase
   end

   assign run_rx_o = run_rx_q;

   ////////////////////
   // LED mix
   ////////////////////

   logic [`SL_LED_W-1:0] led_hw;

   // Bit 1 run, bit 2 data queued, bit 3 FIFO full
   assign led_hw = {4'b0000, fifo_status_i.full, !fifo_status_i.empty, run_rx_q, 1'b0};

   // Source bit 1 picks hardware, 0 picks software
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   // Every ack answers a strobe seen one cycle earlier
   ack_follows_stb: assert property (
      @(posedge dsp_clk) disable iff (!rst_n_i)
      wb_rsp_o.ack |-> $past(wb_req_i.cyc && wb_req_i.stb)
   );

endmodule

// File: sample_link_pkg.sv
////////////////////
// Sample link shared types
// Bus structs, SERDES word, FIFO status and the enums
////////////////////
`include "sample_link_macros.svh"

package sample_link_pkg;

   // Wishbone classic master to slave
   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic                  we;
      logic [`SL_WB_AW-1:0]  adr;
      logic [`SL_WB_DW-1:0]  dat;
   } wb_req_t;

   // Slave to master, no err or rty
   typedef struct packed {
      logic                  ack;
      logic [`SL_WB_DW-1:0]  dat;
   } wb_rsp_t;

   // One SERDES transmit word with its K flags
   typedef struct packed {
      logic [`SL_SER_W-1:0]  data;
      logic                  klsb;
      logic                  kmsb;
   } ser_word_t;

   // Occupancy is in 16-bit halves
   typedef struct packed {
      logic [`SL_FIFO_AW:0]  occupancy;
      logic                  full;
      logic                  empty;
   } fifo_status_t;

   // Register word addresses
   typedef enum logic [`SL_WB_AW-1:0] {
      REG_CTRL    = 3'd0,
      REG_LED_SW  = 3'd1,
      REG_LED_SRC = 3'd2,
      REG_STATUS  = 3'd3,
      REG_OVERRUN = 3'd4,
      REG_COMPAT  = 3'd5
   } reg_addr_e;

   // Framer states
   typedef enum logic [1:0] {
      FR_ALIGN,
      FR_IDLE,
      FR_DATA
   } framer_state_e;

endpackage

// File: sample_link_macros.svh
////////////////////
// Sample link constants
// Widths, FIFO depth, register words and SERDES framing values
////////////////////
`ifndef SAMPLE_LINK_MACROS_SVH
`define SAMPLE_LINK_MACROS_SVH

// Datapath widths
`define SL_SAMPLE_W     32
`define SL_SER_W        16
`define SL_LED_W        8

// Wishbone word address and data widths
`define SL_WB_AW        3
`define SL_WB_DW        32

// Sample FIFO, 16 entries of 32 bits
`define SL_FIFO_AW      4
`define SL_FIFO_DEPTH   (1 << `SL_FIFO_AW)

// K28.5 idle comma in the low byte, sent with tklsb set
`define SL_COMMA        16'h50BC

// Commas sent after reset so the far end can lock
`define SL_ALIGN_WORDS  8

// Bump when the register map or link behaviour changes
`define SL_COMPAT_NUM   4

// Bits 1..4 follow hardware status by default
`define SL_LED_SRC_RST  8'h1E

`endif
